/* rtl/memcopy_pkg.sv */
/* Widths, register map and buffer sizing shared by the memcopy RTL.
   Modules import it inside their bodies and use scoped names in port lists. */
package memcopy_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Word count per copy, up to 65535 words
  localparam int CNT_W = 16;

  // Word buffer, its depth is also the initial credit count
  localparam int BUF_DEPTH = 4;
  localparam int BUF_AW    = $clog2(BUF_DEPTH);

  // Credit and fill counters must reach BUF_DEPTH itself
  localparam int CRED_W = $clog2(BUF_DEPTH + 1);

  // Register port address width and word offsets
  localparam int REG_AW = 4;

  localparam logic [REG_AW-1:0] REG_SRC    = 4'h0;
  localparam logic [REG_AW-1:0] REG_DST    = 4'h4;
  localparam logic [REG_AW-1:0] REG_SIZE   = 4'h8;
  localparam logic [REG_AW-1:0] REG_STATUS = 4'hC;

  // Status register fields
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

/* rtl/memcopy_regs.sv */
/* Register block of the memcopy peripheral. Holds the copy descriptor,
   launches a copy on a nonzero SIZE write and reports busy, done and interrupt. */
`timescale 1ns/1ps

module memcopy_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           reg_valid_i,
  input  logic                           reg_write_i,
  input  logic [memcopy_pkg::REG_AW-1:0] reg_addr_i,
  input  logic [memcopy_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                           reg_ready_o,
  output logic [memcopy_pkg::DATA_W-1:0] reg_rdata_o,
  input  logic                           wr_done_i,
  output logic                           start_o,
  output logic [memcopy_pkg::ADDR_W-1:0] src_o,
  output logic [memcopy_pkg::ADDR_W-1:0] dst_o,
  output logic [memcopy_pkg::CNT_W-1:0]  size_o,
  output logic                           intr_o
);
  import memcopy_pkg::*;

  logic              ready_q;
  logic              busy_q;
  logic              done_q;
  logic              intr_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [CNT_W-1:0]  size_q;
  logic              wr_en;
  logic [DATA_W-1:0] status_word;

  assign wr_en = reg_valid_i && ready_q && reg_write_i;

  // Nonzero count written while idle
  assign start_o = wr_en && !busy_q && (reg_addr_i == REG_SIZE) &&
                   (reg_wdata_i[CNT_W-1:0] != '0);

  assign reg_ready_o = ready_q;
  assign src_o       = src_q;
  assign dst_o       = dst_q;
  assign intr_o      = intr_q;

  // Engines load the count in the start cycle, before size_q updates
  assign size_o = start_o ? reg_wdata_i[CNT_W-1:0] : size_q;

  always_comb begin
    status_word = '0;
    status_word[STATUS_BUSY_BIT] = busy_q;
    status_word[STATUS_DONE_BIT] = done_q;
  end

  always_comb begin
    case (reg_addr_i)
      REG_SRC:    reg_rdata_o = src_q;
      REG_DST:    reg_rdata_o = dst_q;
      REG_SIZE:   reg_rdata_o = {{(DATA_W - CNT_W){1'b0}}, size_q};
      REG_STATUS: reg_rdata_o = status_word;
      default:    reg_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      intr_q  <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
    end else begin
      ready_q <= 1'b1;
      intr_q  <= wr_done_i;
      // Descriptor is frozen while a copy runs
      if (wr_en && !busy_q) begin
        case (reg_addr_i)
          REG_SRC:  src_q  <= reg_wdata_i[ADDR_W-1:0];
          REG_DST:  dst_q  <= reg_wdata_i[ADDR_W-1:0];
          REG_SIZE: size_q <= reg_wdata_i[CNT_W-1:0];
          default:  ;
        endcase
      end
      if (start_o) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (wr_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (wr_en && (reg_addr_i == REG_STATUS) && reg_wdata_i[STATUS_DONE_BIT]) begin
        // Write one to clear done
        done_q <= 1'b0;
      end
    end
  end

  // Writer completion only belongs to a running copy
  assert property (@(posedge clk_i) disable iff (!rst_n_i) wr_done_i |-> busy_q)
    else $error("memcopy_regs: write completion while idle");

endmodule

/* rtl/memcopy_reader.sv */
/* Read engine of the memcopy peripheral. Walks the source range and issues
   one read per cycle while words remain and buffer credits are available. */
`timescale 1ns/1ps

module memcopy_reader (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  logic [memcopy_pkg::ADDR_W-1:0] src_i,
  input  logic [memcopy_pkg::CNT_W-1:0]  size_i,
  input  logic                           credit_i,
  output logic                           rd_req_o,
  output logic [memcopy_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic                           rd_gnt_i
);
  import memcopy_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  left_q;
  logic [CRED_W-1:0] credits_q;
  logic              accept;

  // Address and request only move on a grant
  assign rd_req_o  = (left_q != '0) && (credits_q != '0);
  assign rd_addr_o = addr_q;
  assign accept    = rd_req_o && rd_gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q    <= '0;
      left_q    <= '0;
      credits_q <= CRED_W'(BUF_DEPTH);
    end else if (start_i) begin
      addr_q    <= src_i;
      left_q    <= size_i;
      credits_q <= CRED_W'(BUF_DEPTH);
    end else begin
      if (accept) begin
        addr_q <= addr_q + ADDR_W'(4);
        left_q <= left_q - 1'b1;
      end
      // Spend on an accepted read, refill on a returned credit
      case ({accept, credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: ;
      endcase
    end
  end

  // Returned credits never outnumber the buffer slots
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   credits_q <= CRED_W'(BUF_DEPTH))
    else $error("memcopy_reader: credit count above buffer depth");

endmodule

/* rtl/memcopy_buffer.sv */
/* Word FIFO between the read and write engines. Read data is pushed as it
   returns, the writer pops on grant and each pop sends one credit back. */
`timescale 1ns/1ps

module memcopy_buffer (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           push_i,
  input  logic [memcopy_pkg::DATA_W-1:0] push_data_i,
  input  logic                           pop_i,
  output logic [memcopy_pkg::DATA_W-1:0] head_o,
  output logic                           empty_o,
  output logic                           credit_o
);
  import memcopy_pkg::*;

  logic [DATA_W-1:0] mem_q [BUF_DEPTH];
  logic [BUF_AW-1:0] wr_ptr_q;
  logic [BUF_AW-1:0] rd_ptr_q;
  logic [CRED_W-1:0] count_q;
  logic              credit_q;
  logic              full;
  logic              do_pop;

  assign full     = (count_q == CRED_W'(BUF_DEPTH));
  assign empty_o  = (count_q == '0);
  assign head_o   = mem_q[rd_ptr_q];
  assign credit_o = credit_q;
  assign do_pop   = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      credit_q <= do_pop;
    end
  end

  // Reader credits must keep pushes within the free slots
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full)
    else $error("memcopy_buffer: push while full");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("memcopy_buffer: pop while empty");

endmodule

/* rtl/memcopy_writer.sv */
/* Write engine of the memcopy peripheral. Drains buffered words to successive
   destination addresses and flags completion on the last write response. */
`timescale 1ns/1ps

module memcopy_writer (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  logic [memcopy_pkg::ADDR_W-1:0] dst_i,
  input  logic [memcopy_pkg::CNT_W-1:0]  size_i,
  input  logic                           empty_i,
  input  logic [memcopy_pkg::DATA_W-1:0] head_i,
  output logic                           pop_o,
  output logic                           wr_req_o,
  output logic [memcopy_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [memcopy_pkg::DATA_W-1:0] wr_wdata_o,
  input  logic                           wr_gnt_i,
  input  logic                           wr_rvalid_i,
  output logic                           done_o
);
  import memcopy_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  // Write responses still owed for this copy
  logic [CNT_W-1:0]  pending_q;
  logic              req_q;
  logic              accept;

  assign accept     = req_q && wr_gnt_i;
  assign pop_o      = accept;
  assign wr_req_o   = req_q;
  assign wr_addr_o  = addr_q;
  // Head stays put until the pop, so write data is stable under req
  assign wr_wdata_o = head_i;
  assign done_o     = wr_rvalid_i && (pending_q == CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q    <= '0;
      pending_q <= '0;
      req_q     <= 1'b0;
    end else begin
      if (start_i) begin
        addr_q    <= dst_i;
        pending_q <= size_i;
      end else begin
        if (accept) begin
          addr_q <= addr_q + ADDR_W'(4);
        end
        if (wr_rvalid_i) begin
          pending_q <= pending_q - 1'b1;
        end
      end
      // Request the cycle after a word is seen, drop on grant
      if (accept) begin
        req_q <= 1'b0;
      end else if (!req_q && !empty_i) begin
        req_q <= 1'b1;
      end
    end
  end

endmodule

/* rtl/memcopy_top.sv */
/* Top level of the memcopy peripheral. Wires the register block, read
   engine, word buffer and write engine between the host and memory ports. */
`timescale 1ns/1ps

module memcopy_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Host register port
  input  logic                           reg_valid_i,
  input  logic                           reg_write_i,
  input  logic [memcopy_pkg::REG_AW-1:0] reg_addr_i,
  input  logic [memcopy_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                           reg_ready_o,
  output logic [memcopy_pkg::DATA_W-1:0] reg_rdata_o,
  // Source read port
  output logic                           rd_req_o,
  output logic [memcopy_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic                           rd_gnt_i,
  input  logic                           rd_rvalid_i,
  input  logic [memcopy_pkg::DATA_W-1:0] rd_rdata_i,
  // Destination write port
  output logic                           wr_req_o,
  output logic [memcopy_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [memcopy_pkg::DATA_W-1:0] wr_wdata_o,
  input  logic                           wr_gnt_i,
  input  logic                           wr_rvalid_i,
  output logic                           intr_o
);
  import memcopy_pkg::*;

  logic              start;
  logic [ADDR_W-1:0] src;
  logic [ADDR_W-1:0] dst;
  logic [CNT_W-1:0]  size;
  logic              wr_done;
  logic              credit;
  logic              buf_empty;
  logic [DATA_W-1:0] buf_head;
  logic              buf_pop;

  memcopy_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .wr_done_i   (wr_done),
    .start_o     (start),
    .src_o       (src),
    .dst_o       (dst),
    .size_o      (size),
    .intr_o      (intr_o)
  );

  memcopy_reader u_reader (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (start),
    .src_i     (src),
    .size_i    (size),
    .credit_i  (credit),
    .rd_req_o  (rd_req_o),
    .rd_addr_o (rd_addr_o),
    .rd_gnt_i  (rd_gnt_i)
  );

  // Read responses land straight in the buffer
  memcopy_buffer u_buffer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (rd_rvalid_i),
    .push_data_i (rd_rdata_i),
    .pop_i       (buf_pop),
    .head_o      (buf_head),
    .empty_o     (buf_empty),
    .credit_o    (credit)
  );

  memcopy_writer u_writer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .dst_i       (dst),
    .size_i      (size),
    .empty_i     (buf_empty),
    .head_i      (buf_head),
    .pop_o       (buf_pop),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_wdata_o  (wr_wdata_o),
    .wr_gnt_i    (wr_gnt_i),
    .wr_rvalid_i (wr_rvalid_i),
    .done_o      (wr_done)
  );

endmodule

/* tb/memcopy_checker.sv */
/* Scoreboard for the memcopy testbench. Checks every accepted write against
   reference data, bounds reads in flight ahead of writes and counts interrupts. */
`timescale 1ns/1ps

module memcopy_checker (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           arm_i,
  input  logic [memcopy_pkg::ADDR_W-1:0] exp_src_i,
  input  logic [memcopy_pkg::ADDR_W-1:0] exp_dst_i,
  input  logic                           rd_req_i,
  input  logic                           rd_gnt_i,
  input  logic                           wr_req_i,
  input  logic                           wr_gnt_i,
  input  logic [memcopy_pkg::ADDR_W-1:0] wr_addr_i,
  input  logic [memcopy_pkg::DATA_W-1:0] wr_wdata_i,
  input  logic                           intr_i,
  output int                             err_cnt_o,
  output int                             wr_cnt_o,
  output int                             intr_cnt_o
);
  import memcopy_pkg::*;

  // Reads granted but not yet matched by a granted write
  int ahead;

  // Source memory contents, same rule as the memory model
  function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'h5A3C_96E1;
  endfunction

  always @(posedge clk_i or negedge rst_n_i) begin : watch
    int                fails;
    int                next_ahead;
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_data;
    if (!rst_n_i) begin
      ahead      <= 0;
      err_cnt_o  <= 0;
      wr_cnt_o   <= 0;
      intr_cnt_o <= 0;
    end else begin
      fails = 0;
      next_ahead = ahead + ((rd_req_i && rd_gnt_i) ? 1 : 0)
                         - ((wr_req_i && wr_gnt_i) ? 1 : 0);
      if (next_ahead > BUF_DEPTH) begin
        $display("Fail at %0t ns: %0d reads granted ahead of writes, limit is %0d",
                 $time, next_ahead, BUF_DEPTH);
        fails++;
      end
      ahead <= next_ahead;
      // Word k of the copy goes from src + 4k to dst + 4k
      if (wr_req_i && wr_gnt_i) begin
        exp_addr = exp_dst_i + ADDR_W'(4 * wr_cnt_o);
        exp_data = ref_word(exp_src_i + ADDR_W'(4 * wr_cnt_o));
        if (wr_addr_i !== exp_addr) begin
          $display("Fail at %0t ns: wr_addr_o is %h, expected %h", $time, wr_addr_i, exp_addr);
          fails++;
        end
        if (wr_wdata_i !== exp_data) begin
          $display("Fail at %0t ns: wr_wdata_o is %h, expected %h", $time, wr_wdata_i, exp_data);
          fails++;
        end
      end
      if (arm_i) begin
        wr_cnt_o   <= 0;
        intr_cnt_o <= 0;
      end else begin
        if (wr_req_i && wr_gnt_i) begin
          wr_cnt_o <= wr_cnt_o + 1;
        end
        if (intr_i) begin
          intr_cnt_o <= intr_cnt_o + 1;
        end
      end
      err_cnt_o <= err_cnt_o + fails;
    end
  end

endmodule

/* tb/tb_memcopy.sv */
/* Testbench for the memcopy peripheral. Drives the register port, models a
   slow memory with random grant and response delays and runs the copy tests. */
`timescale 1ns/1ps

module tb_memcopy;
  import memcopy_pkg::*;

  localparam int WAIT_LIMIT = 3000;
  localparam logic [DATA_W-1:0] DONE_ONLY = DATA_W'(1) << STATUS_DONE_BIT;

  logic              clk_i;
  logic              rst_n_i;
  logic              reg_valid_i;
  logic              reg_write_i;
  logic [REG_AW-1:0] reg_addr_i;
  logic [DATA_W-1:0] reg_wdata_i;
  logic              reg_ready_o;
  logic [DATA_W-1:0] reg_rdata_o;
  logic              rd_req_o;
  logic [ADDR_W-1:0] rd_addr_o;
  logic              rd_gnt_i;
  logic              rd_rvalid_i;
  logic [DATA_W-1:0] rd_rdata_i;
  logic              wr_req_o;
  logic [ADDR_W-1:0] wr_addr_o;
  logic [DATA_W-1:0] wr_wdata_o;
  logic              wr_gnt_i;
  logic              wr_rvalid_i;
  logic              intr_o;

  logic              arm;
  logic [ADDR_W-1:0] exp_src;
  logic [ADDR_W-1:0] exp_dst;
  logic              wr_stall;
  int                chk_errs;
  int                chk_writes;
  int                chk_intrs;

  // Memory model state
  int                seed = 62;
  int                cyc = 0;
  int                rd_wait = 0;
  int                wr_wait = 0;
  logic [ADDR_W-1:0] rd_pend[$];
  int                rd_due[$];
  int                wr_due[$];

  int errors = 0;
  int passed = 0;
  int failed = 0;
  int mark = 0;
  logic timed_out = 1'b0;

  memcopy_top UUT (.*);

  memcopy_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .arm_i      (arm),
    .exp_src_i  (exp_src),
    .exp_dst_i  (exp_dst),
    .rd_req_i   (rd_req_o),
    .rd_gnt_i   (rd_gnt_i),
    .wr_req_i   (wr_req_o),
    .wr_gnt_i   (wr_gnt_i),
    .wr_addr_i  (wr_addr_o),
    .wr_wdata_i (wr_wdata_o),
    .intr_i     (intr_o),
    .err_cnt_o  (chk_errs),
    .wr_cnt_o   (chk_writes),
    .intr_cnt_o (chk_intrs)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'h5A3C_96E1;
  endfunction

  // Slow memory, grants after 0 to 3 cycles and answers in order
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (rd_req_o && rd_gnt_i) begin
      rd_pend.push_back(rd_addr_o);
      rd_due.push_back(cyc + ($random(seed) & 3));
      rd_wait = $random(seed) & 3;
    end else if (rd_req_o && rd_wait > 0) begin
      rd_wait--;
    end
    rd_gnt_i <= (rd_wait == 0);
    if (rd_due.size() != 0 && rd_due[0] <= cyc) begin
      rd_rvalid_i <= 1'b1;
      rd_rdata_i  <= ref_word(rd_pend.pop_front());
      void'(rd_due.pop_front());
    end else begin
      rd_rvalid_i <= 1'b0;
    end
    if (wr_req_o && wr_gnt_i) begin
      wr_due.push_back(cyc + ($random(seed) & 3));
      wr_wait = $random(seed) & 3;
    end else if (wr_req_o && wr_wait > 0) begin
      wr_wait--;
    end
    wr_gnt_i <= !wr_stall && (wr_wait == 0);
    if (wr_due.size() != 0 && wr_due[0] <= cyc) begin
      wr_rvalid_i <= 1'b1;
      void'(wr_due.pop_front());
    end else begin
      wr_rvalid_i <= 1'b0;
    end
  end

  // Reports a stuck wait and parks the calling process for good
  task automatic abort(input string why);
    $display("Timeout at %0t ns: %s", $time, why);
    timed_out = 1'b1;
    forever @(posedge clk_i);
  endtask

  // A stuck wait ends the run here
  initial begin : timeout_end
    wait (timed_out);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called on a rising edge, returns on the edge that completes the access
  task automatic reg_access(input logic wr, input logic [REG_AW-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int waited;
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!reg_ready_o && waited < 50);
    if (!reg_ready_o) begin
      abort("register port never became ready");
    end
    rdata = reg_rdata_o;
    reg_valid_i <= 1'b0;
  endtask

  task automatic start_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                            input int n);
    logic [DATA_W-1:0] rd;
    exp_src <= src;
    exp_dst <= dst;
    arm     <= 1'b1;
    reg_access(1'b1, REG_SRC, src, rd);
    arm <= 1'b0;
    reg_access(1'b1, REG_DST, dst, rd);
    reg_access(1'b1, REG_SIZE, 32'(n), rd);
  endtask

  task automatic finish_copy(input int n);
    int                waited;
    logic [DATA_W-1:0] rd;
    waited = 0;
    while (chk_intrs == 0 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (chk_intrs == 0) begin
      abort("copy never raised intr_o");
    end
    // Room for a stray second interrupt to show up
    repeat (4) @(posedge clk_i);
    check_eq("write count", 32'(chk_writes), 32'(n));
    check_eq("intr_o pulses", 32'(chk_intrs), 32'd1);
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_eq("reg_rdata_o (STATUS)", rd, DONE_ONLY);
  endtask

  task automatic end_test(input string name);
    int now;
    now = errors + chk_errs;
    if (now == mark) begin
      $display("ok    %s", name);
      passed++;
    end else begin
      $display("bad   %s, %0d errors", name, now - mark);
      failed++;
    end
    mark = now;
  endtask

  initial begin : sequence_run
    logic [DATA_W-1:0] rd;
    rst_n_i     = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    rd_gnt_i    = 1'b0;
    rd_rvalid_i = 1'b0;
    rd_rdata_i  = '0;
    wr_gnt_i    = 1'b0;
    wr_rvalid_i = 1'b0;
    arm         = 1'b0;
    exp_src     = '0;
    exp_dst     = '0;
    wr_stall    = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    reg_access(1'b0, REG_STATUS, '0, rd);
    check_eq("reg_rdata_o (STATUS)", rd, '0);
    reg_access(1'b1, REG_SRC, 32'h0000_1000, rd);
    reg_access(1'b1, REG_DST, 32'h0000_2000, rd);
    reg_access(1'b0, REG_SRC, '0, rd);
    check_eq("reg_rdata_o (SRC)", rd, 32'h0000_1000);
    reg_access(1'b0, REG_DST, '0, rd);
    check_eq("reg_rdata_o (DST)", rd, 32'h0000_2000);
    end_test("register readback");

    start_copy(32'h0000_0100, 32'h0000_0800, 1);
    finish_copy(1);
    end_test("single-word copy");

    start_copy(32'h0000_4000, 32'h0000_9000, 20);
    finish_copy(20);
    end_test("20-word copy with random delays");

    // Writes held off so the buffer fills and credits run out
    wr_stall <= 1'b1;
    start_copy(32'h0000_5000, 32'h0000_C000, 12);
    repeat (30) @(posedge clk_i);
    wr_stall <= 1'b0;
    finish_copy(12);
    end_test("write back-pressure");

    start_copy(32'h0000_0300, 32'h0000_0A00, 8);
    reg_access(1'b1, REG_SRC, 32'hDEAD_0000, rd);
    finish_copy(8);
    reg_access(1'b0, REG_SRC, '0, rd);
    check_eq("reg_rdata_o (SRC)", rd, 32'h0000_0300);
    reg_access(1'b1, REG_STATUS, DONE_ONLY, rd);
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_eq("reg_rdata_o (STATUS)", rd, '0);
    reg_access(1'b1, REG_SIZE, '0, rd);
    repeat (20) begin
      @(posedge clk_i);
      if (rd_req_o || wr_req_o) begin
        $display("Fail at %0t ns: memory request after a zero-size write", $time);
        errors++;
      end
    end
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_eq("reg_rdata_o (STATUS)", rd, '0);
    end_test("control rules");

    $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors + chk_errs);
    if (failed == 0 && errors + chk_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/memcopy_pkg.sv
rtl/memcopy_regs.sv
rtl/memcopy_reader.sv
rtl/memcopy_buffer.sv
rtl/memcopy_writer.sv
rtl/memcopy_top.sv
tb/memcopy_checker.sv
tb/tb_memcopy.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_memcopy
FILELIST  := filelist.f
BUILD     := obj_dir
LOG       := sim.log

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
